//--- hw/mem_read_pkg.sv
package mem_read_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w = 4;
    localparam int len_w = 8;

    localparam int line_bytes = 16;
    localparam int line_words = line_bytes / (data_w / 8);
    localparam int cache_lines = 4;
    localparam int offset_w = $clog2(line_bytes);
    localparam int index_w = $clog2(cache_lines);
    localparam int tag_w = addr_w - index_w - offset_w;

    localparam logic [len_w-1:0] refill_len = 8'd3;   // four beats per line.
    localparam logic [2:0] word_size = 3'd2;
    localparam logic [1:0] burst_incr = 2'd1;

    localparam logic [addr_w-1:0] clint_base = 32'h0200_0000;
    localparam logic [addr_w-1:0] clint_mask = 32'hffff_0000;
    localparam logic [addr_w-1:0] mtime_lo_addr = clint_base + 32'h0000_bff8;
    localparam logic [addr_w-1:0] mtime_hi_addr = clint_base + 32'h0000_bffc;

    localparam logic [id_w-1:0] refill_id = 4'd0;
    localparam logic [id_w-1:0] data_id = 4'd1;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [id_w-1:0]   id;
        logic [len_w-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
        logic [id_w-1:0]   id;
    } axi_r_t;

    typedef logic [line_words-1:0][data_w-1:0] line_t;

    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0]      tag;
            logic [index_w-1:0]    index;
            logic [offset_w-3:0]   word_off;
            logic [1:0]            byte_off;
        } fields;
    } fetch_addr_t;

endpackage

//--- hw/icache.sv
`timescale 1ns/100ps

module icache
    import mem_read_pkg::*;
(
    input  logic              clock,
    input  logic              rst,
    input  logic              fetch_valid,
    input  fetch_addr_t       fetch_addr,
    input  logic              flush,
    output logic              fetch_ready,
    output logic              fetch_hit,
    output logic [data_w-1:0] fetch_data,
    output logic              refill_req,
    output logic [addr_w-1:0] refill_addr,
    input  logic              refill_done,
    input  line_t             refill_line
);

    logic [tag_w-1:0]       tag_q [cache_lines];
    line_t                  line_q [cache_lines];
    logic [cache_lines-1:0] valid_q;
    fetch_addr_t            req_q;
    logic                   hit;

    enum logic {idle, wait_refill} state_q;

    assign hit = valid_q[fetch_addr.fields.index] &&
                 (tag_q[fetch_addr.fields.index] == fetch_addr.fields.tag);

    assign refill_req = (state_q == wait_refill);
    assign refill_addr = {req_q.raw[addr_w-1:offset_w], {offset_w{1'b0}}};  // line aligned.

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q <= idle;
            valid_q <= '0;
            fetch_ready <= 1'b0;
        end else begin
            fetch_ready <= 1'b0;
            if (flush) begin
                valid_q <= '0;  // fence.i drops every line.
            end
            case (state_q)
                idle: begin
                    if (fetch_valid) begin
                        if (hit) begin
                            fetch_ready <= 1'b1;
                        end else begin
                            state_q <= wait_refill;
                        end
                    end
                end
                wait_refill: begin
                    if (refill_done) begin
                        valid_q[req_q.fields.index] <= 1'b1;
                        fetch_ready <= 1'b1;
                        state_q <= idle;
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_valid && state_q == idle) begin
            req_q <= fetch_addr;
            fetch_hit <= hit;
            fetch_data <= line_q[fetch_addr.fields.index][fetch_addr.fields.word_off];
        end
        if (refill_done) begin
            tag_q[req_q.fields.index] <= req_q.fields.tag;
            line_q[req_q.fields.index] <= refill_line;
            fetch_data <= refill_line[req_q.fields.word_off];  // answer straight from the new line.
        end
    end

endmodule

//--- hw/icache_refill.sv
`timescale 1ns/100ps

module icache_refill
    import mem_read_pkg::*;
(
    input  logic              clock,
    input  logic              rst,
    input  logic              refill_req,
    input  logic [addr_w-1:0] refill_addr,
    output logic              refill_done,
    output line_t             refill_line,
    output logic              ar_valid,
    output axi_ar_t           ar,
    input  logic              ar_ready,
    input  logic              r_valid,
    input  axi_r_t            r,
    output logic              r_ready
);

    logic [$clog2(line_words)-1:0] beat_q;
    line_t                         buf_q;
    line_t                         line_next;

    enum logic [1:0] {idle, addr_phase, data_phase} state_q;

    assign ar_valid = (state_q == addr_phase);
    assign ar = '{addr: refill_addr, id: refill_id, len: refill_len,
                  size: word_size, burst: burst_incr};
    assign r_ready = (state_q == data_phase);

    // the last beat goes straight to the cache together with the buffered ones.
    always_comb begin
        line_next = buf_q;
        line_next[beat_q] = r.data;
    end

    assign refill_line = line_next;
    assign refill_done = r_valid && r_ready && r.last;

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q <= idle;
            beat_q <= '0;
        end else begin
            case (state_q)
                idle: begin
                    if (refill_req) begin
                        state_q <= addr_phase;
                    end
                end
                addr_phase: begin
                    if (ar_ready) begin
                        beat_q <= '0;
                        state_q <= data_phase;
                    end
                end
                data_phase: begin
                    if (r_valid) begin
                        beat_q <= beat_q + 1'b1;
                        if (r.last) begin
                            state_q <= idle;
                        end
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (r_valid && r_ready) begin
            buf_q <= line_next;
        end
    end

endmodule

//--- hw/read_arbiter.sv
`timescale 1ns/100ps

module read_arbiter
    import mem_read_pkg::*;
(
    input  logic    clock,
    input  logic    rst,
    input  logic    refill_ar_valid,
    input  axi_ar_t refill_ar,
    output logic    refill_ar_ready,
    output logic    refill_r_valid,
    output axi_r_t  refill_r,
    input  logic    refill_r_ready,
    input  logic    data_ar_valid,
    input  axi_ar_t data_ar,
    output logic    data_ar_ready,
    output logic    data_r_valid,
    output axi_r_t  data_r,
    input  logic    data_r_ready,
    output logic    mem_ar_valid,
    output axi_ar_t mem_ar,
    input  logic    mem_ar_ready,
    input  logic    mem_r_valid,
    input  axi_r_t  mem_r,
    output logic    mem_r_ready,
    output logic    clint_ar_valid,
    output axi_ar_t clint_ar,
    input  logic    clint_ar_ready,
    input  logic    clint_r_valid,
    input  axi_r_t  clint_r,
    output logic    clint_r_ready
);

    logic    grant_q;   // high while the data port owns the bus.
    logic    target_q;  // high while the timer is the target.
    axi_ar_t win_ar;
    axi_ar_t sel_ar;
    logic    sel_ar_valid;
    logic    sel_ar_ready;
    axi_r_t  sel_r;
    logic    sel_r_valid;
    logic    sel_r_ready;

    enum logic [1:0] {idle, addr_phase, data_phase} state_q;

    assign win_ar = data_ar_valid ? data_ar : refill_ar;

    assign sel_ar = grant_q ? data_ar : refill_ar;
    assign sel_ar_valid = (state_q == addr_phase) && (grant_q ? data_ar_valid : refill_ar_valid);
    assign sel_ar_ready = (state_q == addr_phase) && (target_q ? clint_ar_ready : mem_ar_ready);
    assign mem_ar_valid = sel_ar_valid && !target_q;
    assign clint_ar_valid = sel_ar_valid && target_q;
    assign mem_ar = sel_ar;
    assign clint_ar = sel_ar;
    assign data_ar_ready = sel_ar_ready && grant_q;
    assign refill_ar_ready = sel_ar_ready && !grant_q;

    assign sel_r = target_q ? clint_r : mem_r;
    assign sel_r_valid = (state_q == data_phase) && (target_q ? clint_r_valid : mem_r_valid);
    assign sel_r_ready = (state_q == data_phase) && (grant_q ? data_r_ready : refill_r_ready);
    assign mem_r_ready = sel_r_ready && !target_q;
    assign clint_r_ready = sel_r_ready && target_q;
    assign data_r = sel_r;
    assign refill_r = sel_r;
    assign data_r_valid = sel_r_valid && grant_q;
    assign refill_r_valid = sel_r_valid && !grant_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q <= idle;
            grant_q <= 1'b0;
            target_q <= 1'b0;
        end else begin
            case (state_q)
                idle: begin
                    if (data_ar_valid || refill_ar_valid) begin
                        grant_q <= data_ar_valid;  // data port wins a tie.
                        target_q <= ((win_ar.addr & clint_mask) == clint_base);
                        state_q <= addr_phase;
                    end
                end
                addr_phase: begin
                    if (sel_ar_valid && sel_ar_ready) begin
                        state_q <= data_phase;
                    end
                end
                data_phase: begin
                    if (sel_r_valid && sel_r_ready && sel_r.last) begin
                        state_q <= idle;
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

endmodule

//--- hw/clint.sv
`timescale 1ns/100ps

module clint
    import mem_read_pkg::*;
(
    input  logic    clock,
    input  logic    rst,
    input  logic    ar_valid,
    input  axi_ar_t ar,
    output logic    ar_ready,
    output logic    r_valid,
    output axi_r_t  r,
    input  logic    r_ready
);

    logic [63:0]       mtime_q;
    logic [data_w-1:0] rdata_q;
    logic [id_w-1:0]   rid_q;

    assign ar_ready = !r_valid;  // one read in flight at a time.
    assign r = '{data: rdata_q, resp: 2'b00, last: 1'b1, id: rid_q};

    always_ff @(posedge clock) begin
        if (rst) begin
            mtime_q <= '0;
            r_valid <= 1'b0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
            if (ar_valid && ar_ready) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // address bit 2 picks the upper half of mtime.
    always_ff @(posedge clock) begin
        if (ar_valid && ar_ready) begin
            rdata_q <= ar.addr[2] ? mtime_q[63:32] : mtime_q[31:0];
            rid_q <= ar.id;
        end
    end

endmodule

//--- hw/mem_read_top.sv
`timescale 1ns/100ps

module mem_read_top
    import mem_read_pkg::*;
(
    input  logic              clock,
    input  logic              rst,
    input  logic              fetch_valid,
    input  fetch_addr_t       fetch_addr,
    input  logic              flush,
    output logic              fetch_ready,
    output logic              fetch_hit,
    output logic [data_w-1:0] fetch_data,
    input  logic              data_ar_valid,
    input  axi_ar_t           data_ar,
    output logic              data_ar_ready,
    output logic              data_r_valid,
    output axi_r_t            data_r,
    input  logic              data_r_ready,
    output logic              mem_ar_valid,
    output axi_ar_t           mem_ar,
    input  logic              mem_ar_ready,
    input  logic              mem_r_valid,
    input  axi_r_t            mem_r,
    output logic              mem_r_ready
);

    logic              refill_req;
    logic [addr_w-1:0] refill_addr;
    logic              refill_done;
    line_t             refill_line;

    logic    refill_ar_valid, refill_ar_ready, refill_r_valid, refill_r_ready;
    axi_ar_t refill_ar;
    axi_r_t  refill_r;
    logic    clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;
    axi_ar_t clint_ar;
    axi_r_t  clint_r;

    icache u_icache (
        .clock, .rst, .fetch_valid, .fetch_addr, .flush,
        .fetch_ready, .fetch_hit, .fetch_data,
        .refill_req, .refill_addr, .refill_done, .refill_line
    );

    icache_refill u_refill (
        .clock, .rst, .refill_req, .refill_addr, .refill_done, .refill_line,
        .ar_valid (refill_ar_valid),
        .ar       (refill_ar),
        .ar_ready (refill_ar_ready),
        .r_valid  (refill_r_valid),
        .r        (refill_r),
        .r_ready  (refill_r_ready)
    );

    read_arbiter u_arbiter (
        .clock, .rst,
        .refill_ar_valid, .refill_ar, .refill_ar_ready,
        .refill_r_valid, .refill_r, .refill_r_ready,
        .data_ar_valid, .data_ar, .data_ar_ready, .data_r_valid, .data_r, .data_r_ready,
        .mem_ar_valid, .mem_ar, .mem_ar_ready, .mem_r_valid, .mem_r, .mem_r_ready,
        .clint_ar_valid, .clint_ar, .clint_ar_ready,
        .clint_r_valid, .clint_r, .clint_r_ready
    );

    clint u_clint (
        .clock, .rst,
        .ar_valid (clint_ar_valid),
        .ar       (clint_ar),
        .ar_ready (clint_ar_ready),
        .r_valid  (clint_r_valid),
        .r        (clint_r),
        .r_ready  (clint_r_ready)
    );

endmodule

//--- dv/mem_read_checker.sv
`timescale 1ns/100ps

module mem_read_checker
    import mem_read_pkg::*;
(
    input logic    clock,
    input logic    rst,
    input logic    fetch_valid,
    input logic    fetch_ready,
    input logic    fetch_hit,
    input logic    mem_ar_valid,
    input axi_ar_t mem_ar,
    input logic    mem_ar_ready
);

    ar_held: assert property (@(posedge clock) disable iff (rst)
        mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar))
        else $error("mem AR dropped or changed before it was accepted");

    refill_burst: assert property (@(posedge clock) disable iff (rst)
        mem_ar_valid && mem_ar.id == refill_id |-> mem_ar.len == refill_len)
        else $error("refill AR on the mem port with a wrong burst length");

    single_answer: assert property (@(posedge clock) disable iff (rst)
        fetch_ready |=> !fetch_ready)
        else $error("fetch_ready high in two cycles in a row");

    hit_latency: assert property (@(posedge clock) disable iff (rst)
        fetch_ready && fetch_hit |-> $past(fetch_valid))
        else $error("hit answered later than one cycle after its request");

endmodule

bind mem_read_top mem_read_checker u_checker (
    .clock        (clock),
    .rst          (rst),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .fetch_hit    (fetch_hit),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar       (mem_ar),
    .mem_ar_ready (mem_ar_ready)
);

//--- dv/tb_mem_read.sv
`timescale 1ns/100ps

module tb_mem_read
    import mem_read_pkg::*;
();

    logic              clock;
    logic              rst;
    logic              fetch_valid;
    fetch_addr_t       fetch_addr;
    logic              flush;
    logic              fetch_ready;
    logic              fetch_hit;
    logic [data_w-1:0] fetch_data;
    logic              data_ar_valid;
    axi_ar_t           data_ar;
    logic              data_ar_ready;
    logic              data_r_valid;
    axi_r_t            data_r;
    logic              data_r_ready;
    logic              mem_ar_valid;
    axi_ar_t           mem_ar;
    logic              mem_ar_ready;
    logic              mem_r_valid;
    axi_r_t            mem_r;
    logic              mem_r_ready;

    logic [15:0]       lfsr;
    int                refill_ars;       // refill bursts seen on the mem port.
    logic [len_w-1:0]  refill_len_seen;
    logic [id_w-1:0]   ar_ids [$];        // ID of every mem AR in order of acceptance.
    logic [63:0]       op_q [$];
    logic [31:0]       addr_q [$];
    int                flag_q [$];

    mem_read_top u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("FAIL at %0t: %s, got %h, expected %h",
                               $time, what, got, expected));
        end
    endtask

    // the mem port slave. Word A of memory holds A inverted.
    initial begin : mem_slave
        logic [31:0]      base;
        logic [len_w-1:0] len;
        logic [id_w-1:0]  id;
        int               beat;
        logic             busy;
        logic             r_took;
        lfsr = 16'd2467;
        refill_ars = 0;
        refill_len_seen = '0;
        mem_ar_ready = 1'b0;
        mem_r_valid = 1'b0;
        mem_r = '0;
        busy = 1'b0;
        beat = 0;
        base = '0;
        len = '0;
        id = '0;
        forever begin
            @(posedge clock);
            r_took = mem_r_valid && mem_r_ready;
            if (mem_ar_valid && mem_ar_ready) begin
                base = mem_ar.addr;
                len = mem_ar.len;
                id = mem_ar.id;
                beat = 0;
                busy = 1'b1;
                ar_ids.push_back(mem_ar.id);
                if (mem_ar.id == refill_id) begin
                    refill_ars++;
                    refill_len_seen = mem_ar.len;
                    check_value("refill burst size", 32'(mem_ar.size), 32'(word_size));
                    check_value("refill burst type", 32'(mem_ar.burst), 32'(burst_incr));
                end
            end
            if (r_took) begin
                beat++;
                busy = !mem_r.last;
            end
            @(negedge clock);
            lfsr = lfsr_next(lfsr);
            mem_ar_ready = lfsr[0];
            if (!(mem_r_valid && !r_took)) begin  // a raised beat waits for ready.
                lfsr = lfsr_next(lfsr);
                mem_r_valid = busy && lfsr[0];
                mem_r = '{data: ~(base + 32'(beat << 2)), resp: 2'b00,
                          last: (beat == int'(len)), id: id};
            end
        end
    end

    task automatic do_fetch(input logic [31:0] addr, input logic exp_hit);
        int   waits;
        int   refills_before;
        logic seen;
        @(negedge clock);
        refills_before = refill_ars;
        fetch_addr.raw = addr;
        fetch_valid = 1'b1;
        @(negedge clock);
        fetch_valid = 1'b0;
        waits = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clock);
            waits++;
            seen = fetch_ready;
            if (!seen && waits > 200) begin
                fail_run("timeout while waiting for the cache to answer a fetch");
            end
        end
        check_value("fetch data", fetch_data, ~{addr[31:2], 2'b00});
        check_value("fetch hit flag", 32'(fetch_hit), 32'(exp_hit));
        if (exp_hit) begin
            check_value("hit latency in cycles", waits, 1);
            check_value("refill bursts on a hit", refill_ars - refills_before, 0);
        end else begin
            check_value("refill bursts on a miss", refill_ars - refills_before, 1);
            check_value("refill burst length", 32'(refill_len_seen), 32'(refill_len));
        end
    endtask

    task automatic do_data(input logic [31:0] addr, output logic [31:0] rdata);
        int   waits;
        logic done;
        @(negedge clock);
        data_ar = '{addr: addr, id: data_id, len: 8'd0, size: word_size, burst: burst_incr};
        data_ar_valid = 1'b1;
        waits = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clock);
            waits++;
            done = data_ar_ready;
            if (!done && waits > 200) begin
                fail_run("timeout while waiting for the data port to accept its address");
            end
        end
        @(negedge clock);
        data_ar_valid = 1'b0;
        waits = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clock);
            waits++;
            done = data_r_valid;  // data_r_ready stays high.
            if (!done && waits > 200) begin
                fail_run("timeout while waiting for read data on the data port");
            end
        end
        rdata = data_r.data;
        check_value("data read ID", 32'(data_r.id), 32'(data_id));
        check_value("data read last flag", 32'(data_r.last), 1);
        check_value("data read response", 32'(data_r.resp), 32'd0);
    endtask

    initial begin : main
        int          fd;
        int          i;
        int          flag;
        int          ids_before;
        string       line;
        logic [63:0] op;
        logic [31:0] addr;
        logic [31:0] rdata;
        logic [31:0] prev_lo;
        logic        have_lo;
        $timeformat(-9, 0, " ns", 0);
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr = '0;
        flush = 1'b0;
        data_ar_valid = 1'b0;
        data_ar = '0;
        data_r_ready = 1'b1;
        have_lo = 1'b0;
        prev_lo = '0;
        rdata = '0;
        fd = $fopen("dv/mem_read_cases.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the cases file dv/mem_read_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%s %h %d", op, addr, flag) == 3) begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    flag_q.push_back(flag);
                end
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            fail_run("the cases file holds no operations");
        end
        repeat (3) @(negedge clock);
        rst = 1'b0;
        i = 0;
        while (i < op_q.size()) begin
            op = op_q[i];
            addr = addr_q[i];
            flag = flag_q[i];
            if (op == "fetch") begin
                do_fetch(addr, flag != 0);
            end else if (op == "flush") begin
                @(negedge clock);
                flush = 1'b1;
                @(negedge clock);
                flush = 1'b0;
            end else if (op == "mtime") begin
                repeat (flag) @(negedge clock);
                do_data(addr, rdata);
                if (addr[2]) begin
                    check_value("mtime high word", rdata, 32'd0);
                end else begin
                    if (have_lo) begin
                        check_value("mtime advance between reads",
                                    32'(rdata > prev_lo && (rdata - prev_lo) >= 32'(flag)), 1);
                    end
                    prev_lo = rdata;
                    have_lo = 1'b1;
                end
            end else if (op == "data" && flag != 0 && i + 1 < op_q.size()) begin
                ids_before = ar_ids.size();
                fork
                    begin
                        repeat (2) @(negedge clock);  // meets the refill AR at the arbiter.
                        do_data(addr, rdata);
                    end
                    do_fetch(addr_q[i+1], flag_q[i+1] != 0);
                join
                check_value("data read", rdata, ~addr);
                check_value("first mem AR of the pair", 32'(ar_ids[ids_before]), 32'(data_id));
                i++;  // the paired fetch is done.
            end else if (op == "data") begin
                do_data(addr, rdata);
                check_value("data read", rdata, ~addr);
            end else begin
                fail_run("the cases file holds an unknown operation");
            end
            i++;
        end
        repeat (2) @(negedge clock);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- dv/mem_read_cases.txt
# op     address   flag
# flag is the expected hit for fetch, the idle cycles before an mtime read,
# and 1 on a data read that goes out together with the fetch on the next line.
fetch    00001000  0
fetch    00001008  1
fetch    0000100c  1
fetch    00002004  0
fetch    00001004  0
fetch    00002008  0
fetch    00001010  0
fetch    00001014  1
flush    00000000  0
fetch    00001014  0
fetch    0000101c  1
data     00008000  0
data     0000a404  0
data     7ffffff0  0
mtime    0200bff8  0
mtime    0200bff8  20
mtime    0200bffc  0
data     00009000  1
fetch    00003020  0
fetch    00003024  1

//--- vlog.f
hw/mem_read_pkg.sv
hw/icache.sv
hw/icache_refill.sv
hw/read_arbiter.sv
hw/clint.sv
hw/mem_read_top.sv
dv/mem_read_checker.sv
dv/tb_mem_read.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_mem_read
RTL_TOP    ?= mem_read_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "run ended without passing"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
